//--- design/mcu_pkg.sv
package mcu_pkg;

   ////////////////////
   // widths that mean something
   typedef logic [7:0]  byte_t;        // data or code byte
   typedef logic [9:0]  code_addr_t;   // 1k program RAM
   typedef logic [15:0] dptr_t;        // external data pointer

   ////////////////////
   // state machines
   typedef enum logic [2:0] {
      ST_FETCH,
      ST_DECODE0,
      ST_DECODE1,
      ST_DECODE2,
      ST_EXECUTE
   } cpu_state_e;

   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_SEND} tx_state_e;

   ////////////////////
   // opcodes of the kept subset, everything else runs as a nop
   localparam byte_t OP_LJMP   = 8'h02;   // ljmp addr16
   localparam byte_t OP_INCA   = 8'h04;
   localparam byte_t OP_DECA   = 8'h14;
   localparam byte_t OP_ADDAI  = 8'h24;
   localparam byte_t OP_ADDCI  = 8'h34;
   localparam byte_t OP_JC     = 8'h40;
   localparam byte_t OP_ORLAI  = 8'h44;
   localparam byte_t OP_JNC    = 8'h50;
   localparam byte_t OP_ANLAI  = 8'h54;
   localparam byte_t OP_JZ     = 8'h60;
   localparam byte_t OP_XRLAI  = 8'h64;
   localparam byte_t OP_JNZ    = 8'h70;
   localparam byte_t OP_MOVAI  = 8'h74;
   localparam byte_t OP_SJMP   = 8'h80;
   localparam byte_t OP_MOVDP  = 8'h90;   // mov dptr,#imm16
   localparam byte_t OP_SUBBAI = 8'h94;
   localparam byte_t OP_CLRC   = 8'hC3;
   localparam byte_t OP_SETBC  = 8'hD3;
   localparam byte_t OP_MOVXAD = 8'hE0;   // movx a,@dptr
   localparam byte_t OP_CLRA   = 8'hE4;
   localparam byte_t OP_MOVXDA = 8'hF0;   // movx @dptr,a
   localparam byte_t OP_CPLA   = 8'hF4;

   // transmitter registers in external data space
   localparam dptr_t TX_STATUS_ADDR = 16'h0200;   // bit 0 is busy
   localparam dptr_t TX_DATA_ADDR   = 16'h0201;

endpackage

//--- design/uart_loader.sv
`timescale 1ns/100ps

module uart_loader #(
   parameter int CLKS_PER_BIT = 104,
   parameter int PROG_BYTES   = 512
) (
   input  logic                i_clk,
   input  logic                i_nrst,
   input  logic                i_uart_rx,
   output logic                o_wr,
   output mcu_pkg::code_addr_t o_waddr,
   output mcu_pkg::byte_t      o_wdata,
   output logic                o_load_done
);

   localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

   logic [1:0]          rx_sync;      // two-flop synchronizer
   logic                rx;
   mcu_pkg::rx_state_e  state;
   logic [CNT_W-1:0]    sample_cnt;
   logic [2:0]          bit_cnt;
   mcu_pkg::byte_t      shreg;
   mcu_pkg::code_addr_t byte_cnt;
   logic                load_done;
   logic                full_bit;
   logic                half_bit;

   assign rx       = rx_sync[1];
   assign full_bit = (sample_cnt == CNT_W'(CLKS_PER_BIT));
   assign half_bit = (sample_cnt == CNT_W'(CLKS_PER_BIT / 2));

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_sync <= 2'b11;
      end else begin
         rx_sync <= {rx_sync[0], i_uart_rx};
      end
   end

   ////////////////////
   // receive FSM
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state      <= mcu_pkg::RX_IDLE;
         sample_cnt <= '0;
         bit_cnt    <= '0;
      end else begin
         sample_cnt <= sample_cnt + 1'b1;
         case (state)
            mcu_pkg::RX_IDLE: begin
               sample_cnt <= '0;
               if (!rx) state <= mcu_pkg::RX_START;   // falling edge of start bit
            end
            mcu_pkg::RX_START: begin
               if (half_bit) begin   // middle of start bit
                  sample_cnt <= '0;
                  state      <= rx ? mcu_pkg::RX_IDLE : mcu_pkg::RX_DATA;
               end
            end
            mcu_pkg::RX_DATA: begin
               if (full_bit) begin
                  sample_cnt <= '0;
                  bit_cnt    <= bit_cnt + 1'b1;
                  if (bit_cnt == 3'd7) state <= mcu_pkg::RX_STOP;
               end
            end
            default: begin
               // back to idle at mid stop bit
               if (full_bit) begin
                  sample_cnt <= '0;
                  state      <= mcu_pkg::RX_IDLE;
               end
            end
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (state == mcu_pkg::RX_DATA && full_bit) begin
         shreg <= {rx, shreg[7:1]};   // lsb first
      end
   end

   ////////////////////
   // program RAM writes
   assign o_wr = (state == mcu_pkg::RX_STOP) && full_bit && !load_done;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         byte_cnt  <= '0;
         load_done <= 1'b0;
      end else if (o_wr) begin
         byte_cnt <= byte_cnt + 1'b1;
         if (byte_cnt == mcu_pkg::code_addr_t'(PROG_BYTES - 1)) load_done <= 1'b1;
      end
   end

   assign o_waddr     = byte_cnt;
   assign o_wdata     = shreg;
   assign o_load_done = load_done;

endmodule

//--- design/uart_tx.sv
`timescale 1ns/100ps

module uart_tx #(
   parameter int CLKS_PER_BIT = 104
) (
   input  logic           i_clk,
   input  logic           i_nrst,
   input  logic           i_start,
   input  mcu_pkg::byte_t i_data,
   output logic           o_busy,
   output logic           o_uart_tx
);

   localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

   mcu_pkg::tx_state_e state;
   logic [CNT_W-1:0]   sample_cnt;
   logic [3:0]         bit_cnt;    // 8 data bits then the stop bit
   mcu_pkg::byte_t     shreg;
   logic               bit_end;
   logic               finish;

   assign bit_end = (sample_cnt == CNT_W'(CLKS_PER_BIT));
   assign finish  = (state == mcu_pkg::TX_SEND) && bit_end && (bit_cnt == 4'd8);

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state      <= mcu_pkg::TX_IDLE;
         sample_cnt <= '0;
         bit_cnt    <= '0;
      end else begin
         sample_cnt <= bit_end ? '0 : sample_cnt + 1'b1;
         case (state)
            mcu_pkg::TX_IDLE: begin
               sample_cnt <= '0;
               bit_cnt    <= '0;
               if (i_start) state <= mcu_pkg::TX_START;
            end
            mcu_pkg::TX_START: begin
               if (bit_end) state <= mcu_pkg::TX_SEND;
            end
            default: begin
               if (bit_end) bit_cnt <= bit_cnt + 1'b1;
               if (finish) state <= mcu_pkg::TX_IDLE;
            end
         endcase
      end
   end

   // msb first, ones shift in behind so the stop bit falls out of the register
   always_ff @(posedge i_clk) begin
      if (state == mcu_pkg::TX_IDLE && i_start) begin
         shreg <= i_data;   // a start while busy is simply lost
      end else if (state == mcu_pkg::TX_SEND && bit_end) begin
         shreg <= {shreg[6:0], 1'b1};
      end
   end

   always_comb begin
      case (state)
         mcu_pkg::TX_IDLE:  o_uart_tx = 1'b1;
         mcu_pkg::TX_START: o_uart_tx = 1'b0;
         default:           o_uart_tx = shreg[7];
      endcase
   end

   assign o_busy = (state != mcu_pkg::TX_IDLE);

endmodule

//--- design/code_store.sv
`timescale 1ns/100ps

module code_store #(
   parameter int PROG_BYTES = 512
) (
   input  logic                i_clk,
   input  logic                i_nrst,
   input  logic                i_load_done,
   input  logic                i_wr,
   input  mcu_pkg::code_addr_t i_waddr,
   input  mcu_pkg::byte_t      i_wdata,
   input  mcu_pkg::code_addr_t i_raddr,
   output mcu_pkg::byte_t      o_rdata,
   output logic                o_grant
);

   localparam int AW = (PROG_BYTES > 1) ? $clog2(PROG_BYTES) : 1;

   mcu_pkg::byte_t mem [PROG_BYTES];
   logic           own;   // 0 loader, 1 sequencer

   ////////////////////
   // ownership, one way only
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         own <= 1'b0;
      end else if (i_load_done) begin
         own <= 1'b1;
      end
   end

   ////////////////////
   // byte RAM, synchronous read
   always_ff @(posedge i_clk) begin
      if (i_wr && !own) begin
         mem[i_waddr[AW-1:0]] <= i_wdata;
      end
      if (own) begin
         o_rdata <= mem[i_raddr[AW-1:0]];   // upper address bits alias
      end
   end

   assign o_grant = own;

endmodule

//--- design/cpu_sequencer.sv
`timescale 1ns/100ps

module cpu_sequencer (
   input  logic                i_clk,
   input  logic                i_nrst,
   input  logic                i_grant,
   input  mcu_pkg::byte_t      i_code,
   input  logic                i_acc_zero,
   input  logic                i_carry,
   output mcu_pkg::code_addr_t o_code_addr,
   output mcu_pkg::byte_t      o_opcode,
   output mcu_pkg::byte_t      o_operand,
   output logic                o_exec
);

   mcu_pkg::cpu_state_e state;
   mcu_pkg::code_addr_t pc;
   mcu_pkg::code_addr_t pc_next;
   mcu_pkg::code_addr_t rel_target;
   mcu_pkg::byte_t      opcode;
   mcu_pkg::byte_t      operand;   // immediate, offset or high address byte
   logic [1:0]          len_d0;    // length of the byte just fetched
   logic [1:0]          len_q;
   logic                taken;

   function automatic logic [1:0] instr_len(input mcu_pkg::byte_t op);
      case (op)
         mcu_pkg::OP_LJMP, mcu_pkg::OP_MOVDP:
            instr_len = 2'd3;
         mcu_pkg::OP_MOVAI, mcu_pkg::OP_ADDAI, mcu_pkg::OP_ADDCI, mcu_pkg::OP_SUBBAI,
         mcu_pkg::OP_ORLAI, mcu_pkg::OP_ANLAI, mcu_pkg::OP_XRLAI, mcu_pkg::OP_SJMP,
         mcu_pkg::OP_JZ, mcu_pkg::OP_JNZ, mcu_pkg::OP_JC, mcu_pkg::OP_JNC:
            instr_len = 2'd2;
         default:
            instr_len = 2'd1;
      endcase
   endfunction

   assign len_d0 = instr_len(i_code);
   assign len_q  = instr_len(opcode);

   ////////////////////
   // state and pc
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state  <= mcu_pkg::ST_FETCH;
         pc     <= '0;
         opcode <= '0;
      end else begin
         case (state)
            mcu_pkg::ST_FETCH: begin
               if (i_grant) state <= mcu_pkg::ST_DECODE0;
            end
            mcu_pkg::ST_DECODE0: begin
               opcode <= i_code;
               state  <= (len_d0 == 2'd1) ? mcu_pkg::ST_EXECUTE : mcu_pkg::ST_DECODE1;
            end
            mcu_pkg::ST_DECODE1: begin
               state <= (len_q == 2'd3) ? mcu_pkg::ST_DECODE2 : mcu_pkg::ST_EXECUTE;
            end
            mcu_pkg::ST_DECODE2: state <= mcu_pkg::ST_EXECUTE;
            default: begin
               pc    <= pc_next;
               state <= mcu_pkg::ST_FETCH;
            end
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (state == mcu_pkg::ST_DECODE1) operand <= i_code;
   end

   // held at pc+2 so the low byte of a 3-byte op sits on i_code in execute
   always_comb begin
      case (state)
         mcu_pkg::ST_FETCH:   o_code_addr = pc;
         mcu_pkg::ST_DECODE0: o_code_addr = pc + 10'd1;
         default:             o_code_addr = pc + 10'd2;
      endcase
   end

   ////////////////////
   // branch resolution
   assign rel_target = pc + 10'd2 + {{2{operand[7]}}, operand};   // from next instruction

   always_comb begin
      taken   = 1'b0;
      pc_next = pc + {8'd0, len_q};
      case (opcode)
         mcu_pkg::OP_SJMP: taken = 1'b1;
         mcu_pkg::OP_JZ:   taken = i_acc_zero;
         mcu_pkg::OP_JNZ:  taken = !i_acc_zero;
         mcu_pkg::OP_JC:   taken = i_carry;
         mcu_pkg::OP_JNC:  taken = !i_carry;
         default:          taken = 1'b0;
      endcase
      if (taken) pc_next = rel_target;
      if (opcode == mcu_pkg::OP_LJMP) pc_next = {operand[1:0], i_code};   // 1k space
   end

   assign o_opcode  = opcode;
   assign o_operand = operand;
   assign o_exec    = (state == mcu_pkg::ST_EXECUTE);

endmodule

//--- design/cpu_datapath.sv
`timescale 1ns/100ps

module cpu_datapath (
   input  logic           i_clk,
   input  logic           i_nrst,
   input  logic           i_exec,
   input  mcu_pkg::byte_t i_opcode,
   input  mcu_pkg::byte_t i_operand,
   input  mcu_pkg::byte_t i_operand_lo,
   input  logic           i_tx_busy,
   output logic           o_acc_zero,
   output logic           o_carry,
   output logic           o_tx_start,
   output mcu_pkg::byte_t o_tx_data
);

   mcu_pkg::byte_t acc;
   mcu_pkg::byte_t acc_next;
   logic           carry;
   logic           carry_next;
   mcu_pkg::dptr_t dptr;
   logic           tx_sel;
   logic           status_sel;

   // external data decode
   assign tx_sel     = (dptr == mcu_pkg::TX_DATA_ADDR);
   assign status_sel = (dptr == mcu_pkg::TX_STATUS_ADDR);

   ////////////////////
   // alu
   always_comb begin
      acc_next   = acc;
      carry_next = carry;
      case (i_opcode)
         mcu_pkg::OP_MOVAI: acc_next = i_operand;
         mcu_pkg::OP_ADDAI: {carry_next, acc_next} = {1'b0, acc} + {1'b0, i_operand};
         mcu_pkg::OP_ADDCI: begin
            {carry_next, acc_next} = {1'b0, acc} + {1'b0, i_operand} + {8'd0, carry};
         end
         mcu_pkg::OP_SUBBAI: begin
            // bit 8 ends up as the borrow
            {carry_next, acc_next} = {1'b0, acc} - {1'b0, i_operand} - {8'd0, carry};
         end
         mcu_pkg::OP_ORLAI:  acc_next = acc | i_operand;
         mcu_pkg::OP_ANLAI:  acc_next = acc & i_operand;
         mcu_pkg::OP_XRLAI:  acc_next = acc ^ i_operand;
         mcu_pkg::OP_INCA:   acc_next = acc + 1'b1;   // carry untouched
         mcu_pkg::OP_DECA:   acc_next = acc - 1'b1;
         mcu_pkg::OP_CLRA:   acc_next = 8'h00;
         mcu_pkg::OP_CPLA:   acc_next = ~acc;
         mcu_pkg::OP_CLRC:   carry_next = 1'b0;
         mcu_pkg::OP_SETBC:  carry_next = 1'b1;
         mcu_pkg::OP_MOVXAD: acc_next = {7'd0, i_tx_busy & status_sel};   // unmapped reads 0
         default: ;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         acc   <= '0;
         carry <= 1'b0;
      end else if (i_exec) begin
         acc   <= acc_next;
         carry <= carry_next;
      end
   end

   ////////////////////
   // data pointer
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         dptr <= '0;
      end else if (i_exec && i_opcode == mcu_pkg::OP_MOVDP) begin
         dptr <= {i_operand, i_operand_lo};   // high byte comes first in code
      end
   end

   assign o_tx_start = i_exec && (i_opcode == mcu_pkg::OP_MOVXDA) && tx_sel;
   assign o_tx_data  = acc;
   assign o_acc_zero = (acc == 8'h00);
   assign o_carry    = carry;

endmodule

//--- design/mcu_top.sv
`timescale 1ns/100ps

module mcu_top #(
   parameter int CLKS_PER_BIT = 104,
   parameter int PROG_BYTES   = 512
) (
   input  logic i_clk,
   input  logic i_nrst,
   input  logic i_uart_rx,
   output logic o_uart_tx
);

   // loader side of the program RAM
   logic                wr;
   mcu_pkg::code_addr_t waddr;
   mcu_pkg::byte_t      wdata;
   logic                load_done;

   // fetch side
   mcu_pkg::code_addr_t code_addr;
   mcu_pkg::byte_t      code;
   logic                grant;

   // sequencer to datapath
   mcu_pkg::byte_t      opcode;
   mcu_pkg::byte_t      operand;
   logic                exec;
   logic                acc_zero;
   logic                carry;

   // transmitter
   logic                tx_start;
   mcu_pkg::byte_t      tx_data;
   logic                tx_busy;

   uart_loader #(
      .CLKS_PER_BIT (CLKS_PER_BIT),
      .PROG_BYTES   (PROG_BYTES)
   ) u_loader (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_uart_rx   (i_uart_rx),
      .o_wr        (wr),
      .o_waddr     (waddr),
      .o_wdata     (wdata),
      .o_load_done (load_done)
   );

   code_store #(
      .PROG_BYTES (PROG_BYTES)
   ) u_code (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_load_done (load_done),
      .i_wr        (wr),
      .i_waddr     (waddr),
      .i_wdata     (wdata),
      .i_raddr     (code_addr),
      .o_rdata     (code),
      .o_grant     (grant)
   );

   cpu_sequencer u_seq (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_grant     (grant),
      .i_code      (code),
      .i_acc_zero  (acc_zero),
      .i_carry     (carry),
      .o_code_addr (code_addr),
      .o_opcode    (opcode),
      .o_operand   (operand),
      .o_exec      (exec)
   );

   cpu_datapath u_dp (
      .i_clk        (i_clk),
      .i_nrst       (i_nrst),
      .i_exec       (exec),
      .i_opcode     (opcode),
      .i_operand    (operand),
      .i_operand_lo (code),   // low byte of mov dptr during execute
      .i_tx_busy    (tx_busy),
      .o_acc_zero   (acc_zero),
      .o_carry      (carry),
      .o_tx_start   (tx_start),
      .o_tx_data    (tx_data)
   );

   uart_tx #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) u_tx (
      .i_clk     (i_clk),
      .i_nrst    (i_nrst),
      .i_start   (tx_start),
      .i_data    (tx_data),
      .o_busy    (tx_busy),
      .o_uart_tx (o_uart_tx)
   );

endmodule

//--- testbench/tb_mcu_asserts.sv
`timescale 1ns/100ps

module tb_mcu_asserts #(
   parameter bit SEQ_SIDE = 1'b0   // 1 on the sequencer, 0 on the code store
) (
   input logic       i_clk,
   input logic       i_nrst,
   input logic       i_own,
   input logic       i_wr,
   input logic [2:0] i_state
);

   if (SEQ_SIDE) begin : g_seq
      a_state_legal: assert property (@(posedge i_clk) disable iff (!i_nrst)
         i_state <= 3'd4)
         else $error("sequencer state out of range");

      // sequencer sits in fetch while the loader owns the RAM
      a_idle_before_grant: assert property (@(posedge i_clk) disable iff (!i_nrst)
         !i_own |-> i_state == 3'd0)
         else $error("sequencer left fetch before grant");
   end else begin : g_code
      // hand-over to the sequencer is one way
      a_own_stays: assert property (@(posedge i_clk) disable iff (!i_nrst) !$fell(i_own))
         else $error("ownership fell after being set");

      a_no_late_write: assert property (@(posedge i_clk) disable iff (!i_nrst)
         i_own |-> !i_wr)
         else $error("program write strobe after grant");
   end

endmodule

bind code_store tb_mcu_asserts #(.SEQ_SIDE (1'b0)) u_code_asserts (
   .i_clk   (i_clk),
   .i_nrst  (i_nrst),
   .i_own   (own),
   .i_wr    (i_wr),
   .i_state (3'd0)
);

bind cpu_sequencer tb_mcu_asserts #(.SEQ_SIDE (1'b1)) u_seq_asserts (
   .i_clk   (i_clk),
   .i_nrst  (i_nrst),
   .i_own   (i_grant),
   .i_wr    (1'b0),
   .i_state (state)
);

//--- testbench/tb_mcu.sv
`timescale 1ns/100ps

module tb_mcu;

   localparam int CLKS_PER_BIT = 16;
   localparam int PROG_BYTES   = 128;
   localparam int BIT_CYCLES   = CLKS_PER_BIT + 1;

   logic i_clk;
   logic i_nrst;
   logic i_uart_rx;
   logic o_uart_tx;

   mcu_pkg::byte_t prog [PROG_BYTES];
   int             pc;
   int             errors;
   logic           loading;     // high until the last program byte is sent
   logic           load_sent;
   logic           cmp_done;

   // ops of one test item
   // skip counts are in ops not bytes
   mcu_pkg::byte_t item_op[$];
   mcu_pkg::byte_t item_imm[$];
   int             item_skip[$];

   mcu_pkg::byte_t exp_q[$];
   string          name_q[$];
   mcu_pkg::byte_t rx_q[$];
   int             rx_count;

   mcu_top #(
      .CLKS_PER_BIT (CLKS_PER_BIT),
      .PROG_BYTES   (PROG_BYTES)
   ) u_dut (
      .i_clk     (i_clk),
      .i_nrst    (i_nrst),
      .i_uart_rx (i_uart_rx),
      .o_uart_tx (o_uart_tx)
   );

   always #4 i_clk = ~i_clk;

   ////////////////////
   // checking and ending
   task automatic check_byte(input string name, input mcu_pkg::byte_t exp,
                             input mcu_pkg::byte_t act);
      if (exp !== act) begin
         errors++;
         $display("Fail %s: expected %02h, actual %02h", name, exp, act);
      end
   endtask

   task automatic finish_run();
      $display("errors: %0d, bytes received: %0d", errors, rx_count);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   endtask

   ////////////////////
   // program builder
   function automatic int op_len(input mcu_pkg::byte_t op);
      case (op)
         mcu_pkg::OP_LJMP, mcu_pkg::OP_MOVDP: return 3;
         mcu_pkg::OP_MOVAI, mcu_pkg::OP_ADDAI, mcu_pkg::OP_ADDCI, mcu_pkg::OP_SUBBAI,
         mcu_pkg::OP_ORLAI, mcu_pkg::OP_ANLAI, mcu_pkg::OP_XRLAI, mcu_pkg::OP_SJMP,
         mcu_pkg::OP_JZ, mcu_pkg::OP_JNZ, mcu_pkg::OP_JC, mcu_pkg::OP_JNC: return 2;
         default: return 1;
      endcase
   endfunction

   function automatic logic is_rel_branch(input mcu_pkg::byte_t op);
      return (op == mcu_pkg::OP_SJMP) || (op == mcu_pkg::OP_JZ) || (op == mcu_pkg::OP_JNZ) ||
             (op == mcu_pkg::OP_JC) || (op == mcu_pkg::OP_JNC);
   endfunction

   task automatic put(input mcu_pkg::byte_t b);
      if (pc >= PROG_BYTES) begin
         errors++;
         $display("program does not fit in %0d bytes", PROG_BYTES);
      end else begin
         prog[pc] = b;
         pc++;
      end
   endtask

   task automatic add_op(input mcu_pkg::byte_t op, input mcu_pkg::byte_t imm, input int skip);
      item_op.push_back(op);
      item_imm.push_back(imm);
      item_skip.push_back(skip);
   endtask

   // expected byte of the current item from the instruction rules
   function automatic mcu_pkg::byte_t ref_result();
      mcu_pkg::byte_t acc;
      mcu_pkg::byte_t imm;
      logic           c;
      logic           take;
      int             s;
      int             i;
      acc = 8'h00;   // poll loop exits with acc clear
      c   = 1'b0;
      i   = 0;
      while (i < item_op.size()) begin
         imm  = item_imm[i];
         take = 1'b0;
         case (item_op[i])
            mcu_pkg::OP_MOVAI: acc = imm;
            mcu_pkg::OP_ADDAI: begin
               s   = int'(acc) + int'(imm);
               c   = (s > 255);
               acc = mcu_pkg::byte_t'(s);
            end
            mcu_pkg::OP_ADDCI: begin
               s   = int'(acc) + int'(imm) + int'(c);
               c   = (s > 255);
               acc = mcu_pkg::byte_t'(s);
            end
            mcu_pkg::OP_SUBBAI: begin
               s   = int'(acc) - int'(imm) - int'(c);   // below zero means a borrow
               c   = (s < 0);
               acc = mcu_pkg::byte_t'(s);
            end
            mcu_pkg::OP_ORLAI: acc = acc | imm;
            mcu_pkg::OP_ANLAI: acc = acc & imm;
            mcu_pkg::OP_XRLAI: acc = acc ^ imm;
            mcu_pkg::OP_INCA:  acc = acc + 8'd1;
            mcu_pkg::OP_DECA:  acc = acc - 8'd1;
            mcu_pkg::OP_CLRA:  acc = 8'h00;
            mcu_pkg::OP_CPLA:  acc = ~acc;
            mcu_pkg::OP_CLRC:  c = 1'b0;
            mcu_pkg::OP_SETBC: c = 1'b1;
            mcu_pkg::OP_SJMP, mcu_pkg::OP_LJMP: take = 1'b1;
            mcu_pkg::OP_JZ:    take = (acc == 8'h00);
            mcu_pkg::OP_JNZ:   take = (acc != 8'h00);
            mcu_pkg::OP_JC:    take = c;
            mcu_pkg::OP_JNC:   take = !c;
            default: ;
         endcase
         i = i + 1 + (take ? item_skip[i] : 0);
      end
      return acc;
   endfunction

   // poll loop then computation then send
   task automatic emit_item(input string name);
      int skip_bytes;
      int target;
      put(mcu_pkg::OP_MOVDP);
      put(mcu_pkg::TX_STATUS_ADDR[15:8]);
      put(mcu_pkg::TX_STATUS_ADDR[7:0]);
      put(mcu_pkg::OP_MOVXAD);
      put(mcu_pkg::OP_JNZ);
      put(8'hFD);   // back to the movx
      for (int i = 0; i < item_op.size(); i++) begin
         skip_bytes = 0;
         for (int k = 1; k <= item_skip[i]; k++) skip_bytes += op_len(item_op[i + k]);
         put(item_op[i]);
         if (item_op[i] == mcu_pkg::OP_LJMP) begin
            target = pc + 2 + skip_bytes;
            put(mcu_pkg::byte_t'(target >> 8));
            put(mcu_pkg::byte_t'(target));
         end else if (is_rel_branch(item_op[i])) begin
            put(mcu_pkg::byte_t'(skip_bytes));
         end else if (op_len(item_op[i]) == 2) begin
            put(item_imm[i]);
         end
      end
      put(mcu_pkg::OP_MOVDP);
      put(mcu_pkg::TX_DATA_ADDR[15:8]);
      put(mcu_pkg::TX_DATA_ADDR[7:0]);
      put(mcu_pkg::OP_MOVXDA);
      exp_q.push_back(ref_result());
      name_q.push_back(name);
      item_op.delete();
      item_imm.delete();
      item_skip.delete();
   endtask

   task automatic build_program();
      foreach (prog[i]) prog[i] = 8'h00;
      pc = 0;
      // add then addc with the carry of the add
      // both top bits set so the add always carries
      add_op(mcu_pkg::OP_MOVAI, mcu_pkg::byte_t'($urandom) | 8'h80, 0);
      add_op(mcu_pkg::OP_ADDAI, mcu_pkg::byte_t'($urandom) | 8'h80, 0);
      add_op(mcu_pkg::OP_ADDCI, mcu_pkg::byte_t'($urandom), 0);
      emit_item("add_addc");
      add_op(mcu_pkg::OP_MOVAI, mcu_pkg::byte_t'($urandom), 0);
      add_op(mcu_pkg::OP_SETBC, 8'h00, 0);
      add_op(mcu_pkg::OP_SUBBAI, mcu_pkg::byte_t'($urandom), 0);
      add_op(mcu_pkg::OP_CLRC, 8'h00, 0);
      add_op(mcu_pkg::OP_SUBBAI, mcu_pkg::byte_t'($urandom), 0);
      emit_item("subb");
      add_op(mcu_pkg::OP_MOVAI, mcu_pkg::byte_t'($urandom), 0);
      add_op(mcu_pkg::OP_ORLAI, mcu_pkg::byte_t'($urandom), 0);
      add_op(mcu_pkg::OP_ANLAI, mcu_pkg::byte_t'($urandom), 0);
      add_op(mcu_pkg::OP_XRLAI, mcu_pkg::byte_t'($urandom), 0);
      add_op(mcu_pkg::OP_CPLA, 8'h00, 0);
      add_op(mcu_pkg::OP_INCA, 8'h00, 0);
      add_op(mcu_pkg::OP_DECA, 8'h00, 0);
      add_op(mcu_pkg::OP_DECA, 8'h00, 0);
      emit_item("logic_unary");
      // each marker bit shows which path ran
      add_op(mcu_pkg::OP_CLRA, 8'h00, 0);
      add_op(mcu_pkg::OP_JZ, 8'h00, 1);
      add_op(mcu_pkg::OP_ORLAI, 8'h01, 0);
      add_op(mcu_pkg::OP_JNZ, 8'h00, 1);
      add_op(mcu_pkg::OP_ORLAI, 8'h02, 0);
      add_op(mcu_pkg::OP_JZ, 8'h00, 1);
      add_op(mcu_pkg::OP_ORLAI, 8'h04, 0);
      add_op(mcu_pkg::OP_JNZ, 8'h00, 1);
      add_op(mcu_pkg::OP_ORLAI, 8'h08, 0);
      emit_item("branch_zero");
      add_op(mcu_pkg::OP_CLRA, 8'h00, 0);
      add_op(mcu_pkg::OP_SETBC, 8'h00, 0);
      add_op(mcu_pkg::OP_JC, 8'h00, 1);
      add_op(mcu_pkg::OP_ORLAI, 8'h01, 0);
      add_op(mcu_pkg::OP_JNC, 8'h00, 1);
      add_op(mcu_pkg::OP_ORLAI, 8'h02, 0);
      add_op(mcu_pkg::OP_CLRC, 8'h00, 0);
      add_op(mcu_pkg::OP_JC, 8'h00, 1);
      add_op(mcu_pkg::OP_ORLAI, 8'h04, 0);
      add_op(mcu_pkg::OP_JNC, 8'h00, 1);
      add_op(mcu_pkg::OP_ORLAI, 8'h08, 0);
      add_op(mcu_pkg::OP_SJMP, 8'h00, 1);
      add_op(mcu_pkg::OP_ORLAI, 8'h10, 0);
      add_op(mcu_pkg::OP_LJMP, 8'h00, 1);
      add_op(mcu_pkg::OP_ORLAI, 8'h20, 0);
      emit_item("branch_carry_jump");
      put(mcu_pkg::OP_SJMP);
      put(8'hFE);   // park here
   endtask

   ////////////////////
   // uart driver with lsb first
   task automatic drive_bit(input logic v);
      @(posedge i_clk);
      #1;
      i_uart_rx = v;
      repeat (BIT_CYCLES - 1) @(posedge i_clk);
   endtask

   task automatic send_byte(input mcu_pkg::byte_t b);
      drive_bit(1'b0);
      for (int i = 0; i < 8; i++) drive_bit(b[i]);
      drive_bit(1'b1);
   endtask

   ////////////////////
   // monitor sampling msb first on the falling edge
   initial begin : monitor
      mcu_pkg::byte_t b;
      int             idle;
      rx_count = 0;
      forever begin
         idle = 0;
         while (o_uart_tx !== 1'b0 && idle < 200000) begin
            @(negedge i_clk);
            idle++;
         end
         if (idle >= 200000) disable monitor;
         if (loading) begin
            errors++;
            $display("transmit line went low before the program was loaded");
         end
         repeat (CLKS_PER_BIT / 2) @(negedge i_clk);
         if (o_uart_tx !== 1'b0) begin
            errors++;
            $display("start bit did not stay low to mid bit");
         end
         for (int i = 0; i < 8; i++) begin
            repeat (BIT_CYCLES) @(negedge i_clk);
            b = {b[6:0], o_uart_tx};
         end
         repeat (BIT_CYCLES) @(negedge i_clk);
         if (o_uart_tx !== 1'b1) begin
            errors++;
            $display("stop bit of byte %0d is low", rx_count);
         end
         rx_q.push_back(b);
         rx_count++;
      end
   end

   ////////////////////
   // compare received bytes in order
   initial begin : compare
      int             t;
      mcu_pkg::byte_t got;
      cmp_done = 1'b0;
      t = 0;
      while (load_sent !== 1'b1 && t < 60000) begin
         @(posedge i_clk);
         t++;
      end
      if (load_sent !== 1'b1) begin
         errors++;
         $display("timeout waiting for the program load to finish");
      end
      for (int n = 0; n < exp_q.size(); n++) begin
         t = 0;
         while (rx_q.size() == 0 && t < 5000) begin
            @(posedge i_clk);
            t++;
         end
         if (rx_q.size() == 0) begin
            errors++;
            $display("timeout waiting for byte of %s", name_q[n]);
            break;
         end
         got = rx_q.pop_front();
         check_byte(name_q[n], exp_q[n], got);
      end
      cmp_done = 1'b1;
   end

   initial begin
      int t;
      void'($urandom(37393));
      errors    = 0;
      i_clk     = 1'b0;
      i_nrst    = 1'b0;
      i_uart_rx = 1'b1;
      loading   = 1'b1;
      load_sent = 1'b0;
      build_program();
      repeat (16) @(posedge i_clk);
      #1;
      i_nrst = 1'b1;
      for (int i = 0; i < PROG_BYTES; i++) send_byte(prog[i]);
      loading   = 1'b0;
      load_sent = 1'b1;
      t = 0;
      while (!cmp_done && t < 40000) begin
         @(posedge i_clk);
         t++;
      end
      if (!cmp_done) begin
         errors++;
         $display("timeout waiting for the compare process");
      end
      // room for a stray extra byte to show up
      repeat (20 * BIT_CYCLES) @(posedge i_clk);
      if (rx_count != exp_q.size()) begin
         errors++;
         $display("received %0d bytes but %0d were sent", rx_count, exp_q.size());
      end
      finish_run();
   end

endmodule

//--- sources.f
design/mcu_pkg.sv
design/uart_loader.sv
design/uart_tx.sv
design/code_store.sv
design/cpu_sequencer.sv
design/cpu_datapath.sv
design/mcu_top.sv
testbench/tb_mcu_asserts.sv
testbench/tb_mcu.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the mcu testbench with Verilator
set -u
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_mcu -f sources.f \
   --Mdir obj_dir -o tb_mcu_sim
if [ $? -ne 0 ]; then
   echo "compile failed"
   exit 1
fi

./obj_dir/tb_mcu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Done: errors found" sim.log; then
   exit 1
fi
exit 0
